//--- decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data word width
`define NB_DATA 32

// Register address width
`define NB_ADDR 5

// Number of registers in the bank
`define BANK_DEPTH 32

`endif

//--- mips_isa_pkg.sv
package mips_isa_pkg;

    // Major opcodes handled by the decode stage
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    typedef struct packed {
        opcode_e     opcode; // [31:26]
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;  // Unused by the supported set
        funct_e      funct;  // [5:0]
    } r_fields_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        r_fields_t rtype;
        i_fields_t itype;
    } instr_u;

endpackage

//--- decode_ctrl_pkg.sv
package decode_ctrl_pkg;

    // Operation requested from the execute stage
    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_LUI  = 3'd6  // Pass the shifted immediate through
    } alu_op_e;

    // Control word handed to execute
    typedef struct packed {
        logic    reg_write;  // Result goes back to the bank
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg; // Write-back takes memory data
        logic    alu_src;    // Second operand is the immediate
        logic    branch;
        alu_op_e alu_op;
    } id_ctrl_t;

    // All controls inactive
    localparam id_ctrl_t CTRL_NOP = '{
        reg_write:  1'b0,
        mem_read:   1'b0,
        mem_write:  1'b0,
        mem_to_reg: 1'b0,
        alu_src:    1'b0,
        branch:     1'b0,
        alu_op:     ALU_NONE
    };

endpackage

//--- reg_read_if.sv
`include "decode_params.svh"

interface reg_read_if;

    logic [`NB_ADDR-1:0] read_reg_a; // rs
    logic [`NB_ADDR-1:0] read_reg_b; // rt
    logic [`NB_DATA-1:0] data_a;
    logic [`NB_DATA-1:0] data_b;

    modport decoder (
        output read_reg_a,
        output read_reg_b,
        input  data_a,
        input  data_b
    );

    modport bank (
        input  read_reg_a,
        input  read_reg_b,
        output data_a,
        output data_b
    );

endinterface

//--- register_bank.sv
`include "decode_params.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_enable,
    input  logic                i_reg_write,    // Write strobe from write-back
    input  logic [`NB_ADDR-1:0] i_write_reg,
    input  logic [`NB_DATA-1:0] i_write_data,
    input  logic                i_read_enable,  // Debug unit, honoured while halted
    input  logic [`NB_ADDR-1:0] i_read_address,
    reg_read_if.bank            rd
);

    logic [`NB_DATA-1:0] registers [`BANK_DEPTH];

    logic                write_valid;
    logic                fwd_a;
    logic                fwd_b;
    logic [`NB_DATA-1:0] array_a;
    logic [`NB_DATA-1:0] array_b;
    logic [`NB_DATA-1:0] array_dbg;

    // Register 0 is never a write target
    assign write_valid = i_reg_write && (i_write_reg != '0);

    // Same-cycle write to a register being read
    assign fwd_a = write_valid && (i_write_reg == rd.read_reg_a);
    assign fwd_b = write_valid && (i_write_reg == rd.read_reg_b);

    // Address 0 reads as zero
    assign array_a   = (rd.read_reg_a == '0) ? '0 : registers[rd.read_reg_a];
    assign array_b   = (rd.read_reg_b == '0) ? '0 : registers[rd.read_reg_b];
    assign array_dbg = (i_read_address == '0) ? '0 : registers[i_read_address];

    always_ff @(posedge i_clock) begin
        if (i_enable && write_valid) begin // Writes while halted are dropped
            registers[i_write_reg] <= i_write_data;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rd.data_a <= '0;
            rd.data_b <= '0;
        end else if (i_enable) begin
            rd.data_a <= fwd_a ? i_write_data : array_a;
            rd.data_b <= fwd_b ? i_write_data : array_b;
        end else if (i_read_enable) begin
            // Debug read on port a, port b holds
            rd.data_a <= array_dbg;
        end
    end

    // Register 0 reads back as zero on either path
    property p_zero_reg_a;
        @(posedge i_clock) disable iff (i_reset)
        ((i_enable && rd.read_reg_a == '0) ||
         (!i_enable && i_read_enable && i_read_address == '0))
        |=> (rd.data_a == '0);
    endproperty

    property p_zero_reg_b;
        @(posedge i_clock) disable iff (i_reset)
        (i_enable && rd.read_reg_b == '0) |=> (rd.data_b == '0);
    endproperty

    property p_reset_clears;
        @(posedge i_clock)
        i_reset |=> (rd.data_a == '0 && rd.data_b == '0);
    endproperty

    a_zero_reg_a: assert property (p_zero_reg_a)
        else $error("register_bank: register 0 read nonzero on port a");

    a_zero_reg_b: assert property (p_zero_reg_b)
        else $error("register_bank: register 0 read nonzero on port b");

    a_reset_clears: assert property (p_reset_clears)
        else $error("register_bank: read data not cleared after reset");

endmodule

//--- instruction_decoder.sv
`include "decode_params.svh"

module instruction_decoder (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_enable,
    input  mips_isa_pkg::instr_u       i_instruction,
    reg_read_if.decoder                rd,
    output decode_ctrl_pkg::id_ctrl_t  o_ctrl,
    output logic [`NB_DATA-1:0]        o_immediate,
    output logic [`NB_ADDR-1:0]        o_dest_reg,
    output logic                       o_illegal
);

    decode_ctrl_pkg::id_ctrl_t ctrl_next;
    decode_ctrl_pkg::alu_op_e  r_alu_op;
    logic                      r_known;
    logic [`NB_DATA-1:0]       imm_next;
    logic [`NB_ADDR-1:0]       dest_next;
    logic                      illegal_next;
    logic [15:0]               imm16;

    // Source registers sit in the same place for both formats
    assign rd.read_reg_a = i_instruction.itype.rs;
    assign rd.read_reg_b = i_instruction.itype.rt;

    assign imm16 = i_instruction.itype.imm;

    // Funct decode through the R view
    always_comb begin
        r_known  = 1'b1;
        r_alu_op = decode_ctrl_pkg::ALU_NONE;
        case (i_instruction.rtype.funct)
            mips_isa_pkg::FN_ADD: r_alu_op = decode_ctrl_pkg::ALU_ADD;
            mips_isa_pkg::FN_SUB: r_alu_op = decode_ctrl_pkg::ALU_SUB;
            mips_isa_pkg::FN_AND: r_alu_op = decode_ctrl_pkg::ALU_AND;
            mips_isa_pkg::FN_OR:  r_alu_op = decode_ctrl_pkg::ALU_OR;
            mips_isa_pkg::FN_SLT: r_alu_op = decode_ctrl_pkg::ALU_SLT;
            default:              r_known  = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_next    = decode_ctrl_pkg::CTRL_NOP;
        illegal_next = 1'b0;
        dest_next    = i_instruction.itype.rt;        // I-type writes rt
        imm_next     = {{16{imm16[15]}}, imm16};      // Sign extend by default

        case (i_instruction.itype.opcode)
            mips_isa_pkg::OP_RTYPE: begin
                dest_next = i_instruction.rtype.rd;
                if (r_known) begin
                    ctrl_next.reg_write = 1'b1;
                    ctrl_next.alu_op    = r_alu_op;
                end else begin
                    illegal_next = 1'b1;
                end
            end
            mips_isa_pkg::OP_ADDI: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.alu_op    = decode_ctrl_pkg::ALU_ADD;
            end
            mips_isa_pkg::OP_ANDI: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.alu_op    = decode_ctrl_pkg::ALU_AND;
                imm_next            = {16'b0, imm16}; // Logical ops zero extend
            end
            mips_isa_pkg::OP_ORI: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.alu_op    = decode_ctrl_pkg::ALU_OR;
                imm_next            = {16'b0, imm16};
            end
            mips_isa_pkg::OP_LW: begin
                ctrl_next.reg_write  = 1'b1;
                ctrl_next.mem_read   = 1'b1;
                ctrl_next.mem_to_reg = 1'b1;
                ctrl_next.alu_src    = 1'b1;
                ctrl_next.alu_op     = decode_ctrl_pkg::ALU_ADD; // Address calc
            end
            mips_isa_pkg::OP_SW: begin
                ctrl_next.mem_write = 1'b1;
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.alu_op    = decode_ctrl_pkg::ALU_ADD;
            end
            mips_isa_pkg::OP_BEQ: begin
                ctrl_next.branch = 1'b1;
                ctrl_next.alu_op = decode_ctrl_pkg::ALU_SUB; // Compare rs and rt
            end
            mips_isa_pkg::OP_LUI: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.alu_op    = decode_ctrl_pkg::ALU_LUI;
                imm_next            = {imm16, 16'b0};
            end
            default: begin
                illegal_next = 1'b1;
            end
        endcase
    end

    // Registered to line up with the bank read data
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_ctrl      <= decode_ctrl_pkg::CTRL_NOP;
            o_immediate <= '0;
            o_dest_reg  <= '0;
            o_illegal   <= 1'b0;
        end else if (i_enable) begin
            o_ctrl      <= ctrl_next;
            o_immediate <= imm_next;
            o_dest_reg  <= dest_next;
            o_illegal   <= illegal_next;
        end
    end

    a_mem_exclusive: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(o_ctrl.mem_read && o_ctrl.mem_write))
        else $error("instruction_decoder: mem_read and mem_write both high");

endmodule

//--- decode_stage.sv
`include "decode_params.svh"

module decode_stage (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_enable,       // Pipeline advances
    input  logic [31:0]              i_instruction,

    // Write-back port
    input  logic                     i_reg_write,
    input  logic [`NB_ADDR-1:0]      i_write_reg,
    input  logic [`NB_DATA-1:0]      i_write_data,

    // Debug unit port
    input  logic                     i_read_enable,
    input  logic [`NB_ADDR-1:0]      i_read_address,

    output logic [`NB_DATA-1:0]      o_data_a,
    output logic [`NB_DATA-1:0]      o_data_b,
    output logic [`NB_DATA-1:0]      o_immediate,
    output logic [`NB_ADDR-1:0]      o_dest_reg,

    // Control to execute
    output logic                     o_reg_write,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_mem_to_reg,
    output logic                     o_alu_src,
    output logic                     o_branch,
    output decode_ctrl_pkg::alu_op_e o_alu_op,
    output logic                     o_illegal
);

    reg_read_if rd_if ();

    decode_ctrl_pkg::id_ctrl_t id_ctrl;

    instruction_decoder decoder_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_enable      (i_enable),
        .i_instruction (i_instruction),
        .rd            (rd_if.decoder),
        .o_ctrl        (id_ctrl),
        .o_immediate   (o_immediate),
        .o_dest_reg    (o_dest_reg),
        .o_illegal     (o_illegal)
    );

    register_bank bank_i (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (i_enable),
        .i_reg_write    (i_reg_write),
        .i_write_reg    (i_write_reg),
        .i_write_data   (i_write_data),
        .i_read_enable  (i_read_enable),
        .i_read_address (i_read_address),
        .rd             (rd_if.bank)
    );

    assign o_data_a = rd_if.data_a;
    assign o_data_b = rd_if.data_b;

    // Control word out as separate lines
    assign o_reg_write  = id_ctrl.reg_write;
    assign o_mem_read   = id_ctrl.mem_read;
    assign o_mem_write  = id_ctrl.mem_write;
    assign o_mem_to_reg = id_ctrl.mem_to_reg;
    assign o_alu_src    = id_ctrl.alu_src;
    assign o_branch     = id_ctrl.branch;
    assign o_alu_op     = id_ctrl.alu_op;

endmodule

//--- tb_decode_stage.sv
`include "decode_params.svh"

module tb_decode_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 8;
    localparam int FILL_OPS     = `BANK_DEPTH;
    localparam int RANDOM_OPS   = 200;
    localparam int DIRECTED_OPS = 40;
    localparam int HALT_OPS     = 20;
    localparam int MAX_CYCLES   = RESET_CYCLES + FILL_OPS + RANDOM_OPS + DIRECTED_OPS
                                  + HALT_OPS + 50;

    localparam logic [5:0] I_OPS [7] = '{
        mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI,
        mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW, mips_isa_pkg::OP_BEQ,
        mips_isa_pkg::OP_LUI
    };
    localparam logic [5:0] R_FUNCTS [5] = '{
        mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_AND,
        mips_isa_pkg::FN_OR, mips_isa_pkg::FN_SLT
    };
    localparam logic [15:0] TEST_IMMS [2] = '{16'h8001, 16'h7FFE}; // Negative and positive

    typedef struct packed {
        decode_ctrl_pkg::id_ctrl_t ctrl;
        logic [`NB_DATA-1:0]       imm;
        logic [`NB_ADDR-1:0]       dest;
        logic                      illegal;
    } decode_exp_t;

    logic                     i_clock;
    logic                     i_reset;
    logic                     i_enable;
    logic [31:0]              i_instruction;
    logic                     i_reg_write;
    logic [`NB_ADDR-1:0]      i_write_reg;
    logic [`NB_DATA-1:0]      i_write_data;
    logic                     i_read_enable;
    logic [`NB_ADDR-1:0]      i_read_address;
    logic [`NB_DATA-1:0]      o_data_a;
    logic [`NB_DATA-1:0]      o_data_b;
    logic [`NB_DATA-1:0]      o_immediate;
    logic [`NB_ADDR-1:0]      o_dest_reg;
    logic                     o_reg_write;
    logic                     o_mem_read;
    logic                     o_mem_write;
    logic                     o_mem_to_reg;
    logic                     o_alu_src;
    logic                     o_branch;
    decode_ctrl_pkg::alu_op_e o_alu_op;
    logic                     o_illegal;

    logic [`NB_DATA-1:0] model_regs [`BANK_DEPTH];
    logic [`NB_DATA-1:0] exp_data_a;
    logic [`NB_DATA-1:0] exp_data_b;
    decode_exp_t         exp_dec;
    logic                exp_valid   = 1'b0; // No expectation before the first edge
    logic [31:0]         rng_state   = 32'h08228037;
    int                  cycle_count = 0;

    decode_stage dut_i (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (i_enable),
        .i_instruction  (i_instruction),
        .i_reg_write    (i_reg_write),
        .i_write_reg    (i_write_reg),
        .i_write_data   (i_write_data),
        .i_read_enable  (i_read_enable),
        .i_read_address (i_read_address),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b),
        .o_immediate    (o_immediate),
        .o_dest_reg     (o_dest_reg),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_to_reg   (o_mem_to_reg),
        .o_alu_src      (o_alu_src),
        .o_branch       (o_branch),
        .o_alu_op       (o_alu_op),
        .o_illegal      (o_illegal)
    );

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] make_r(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
        mips_isa_pkg::instr_u ins;
        ins.rtype.opcode = mips_isa_pkg::OP_RTYPE;
        ins.rtype.rs     = rs;
        ins.rtype.rt     = rt;
        ins.rtype.rd     = rd;
        ins.rtype.shamt  = '0;
        ins.rtype.funct  = mips_isa_pkg::funct_e'(funct);
        return ins;
    endfunction

    function automatic logic [31:0] make_i(input logic [5:0] opcode, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        mips_isa_pkg::instr_u ins;
        ins.itype.opcode = mips_isa_pkg::opcode_e'(opcode);
        ins.itype.rs     = rs;
        ins.itype.rt     = rt;
        ins.itype.imm    = imm;
        return ins;
    endfunction

    // Flags are {reg_write, mem_read, mem_write, mem_to_reg, alu_src, branch}
    function automatic decode_ctrl_pkg::id_ctrl_t control_flags(
        input logic [5:0] flags, input decode_ctrl_pkg::alu_op_e op);
        return {flags, op};
    endfunction

    // Expected decode of one instruction word
    function automatic decode_exp_t decode_reference(input logic [31:0] word);
        decode_exp_t e;
        logic [15:0] imm;
        imm       = word[15:0];
        e.ctrl    = control_flags(6'b00_0000, decode_ctrl_pkg::ALU_NONE);
        e.illegal = 1'b0;
        e.dest    = word[20:16];
        e.imm     = {{16{imm[15]}}, imm};
        case (word[31:26])
            mips_isa_pkg::OP_RTYPE: begin
                e.dest = word[15:11];
                case (word[5:0])
                    mips_isa_pkg::FN_ADD: e.ctrl = control_flags(6'b10_0000, decode_ctrl_pkg::ALU_ADD);
                    mips_isa_pkg::FN_SUB: e.ctrl = control_flags(6'b10_0000, decode_ctrl_pkg::ALU_SUB);
                    mips_isa_pkg::FN_AND: e.ctrl = control_flags(6'b10_0000, decode_ctrl_pkg::ALU_AND);
                    mips_isa_pkg::FN_OR:  e.ctrl = control_flags(6'b10_0000, decode_ctrl_pkg::ALU_OR);
                    mips_isa_pkg::FN_SLT: e.ctrl = control_flags(6'b10_0000, decode_ctrl_pkg::ALU_SLT);
                    default:              e.illegal = 1'b1;
                endcase
            end
            mips_isa_pkg::OP_ADDI: e.ctrl = control_flags(6'b10_0010, decode_ctrl_pkg::ALU_ADD);
            mips_isa_pkg::OP_ANDI: begin
                e.ctrl = control_flags(6'b10_0010, decode_ctrl_pkg::ALU_AND);
                e.imm  = {16'h0000, imm};
            end
            mips_isa_pkg::OP_ORI: begin
                e.ctrl = control_flags(6'b10_0010, decode_ctrl_pkg::ALU_OR);
                e.imm  = {16'h0000, imm};
            end
            mips_isa_pkg::OP_LW:  e.ctrl = control_flags(6'b11_0110, decode_ctrl_pkg::ALU_ADD);
            mips_isa_pkg::OP_SW:  e.ctrl = control_flags(6'b00_1010, decode_ctrl_pkg::ALU_ADD);
            mips_isa_pkg::OP_BEQ: e.ctrl = control_flags(6'b00_0001, decode_ctrl_pkg::ALU_SUB);
            mips_isa_pkg::OP_LUI: begin
                e.ctrl = control_flags(6'b10_0010, decode_ctrl_pkg::ALU_LUI);
                e.imm  = {imm, 16'h0000};
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    // Read with same-cycle write-back bypass
    function automatic logic [31:0] forwarded_read(input logic [4:0] addr);
        if (addr == '0) return '0;
        if (i_reg_write && i_write_reg == addr) return i_write_data;
        return model_regs[addr];
    endfunction

    function automatic logic [31:0] debug_read(input logic [4:0] addr);
        return (addr == '0) ? '0 : model_regs[addr];
    endfunction

    // One-cycle expectation record
    always @(posedge i_clock) begin
        exp_valid <= 1'b1;
        if (i_reset) begin
            exp_data_a <= '0;
            exp_data_b <= '0;
            exp_dec    <= '0; // ALU_NONE encodes as zero
        end else if (i_enable) begin
            exp_data_a <= forwarded_read(i_instruction[25:21]);
            exp_data_b <= forwarded_read(i_instruction[20:16]);
            exp_dec    <= decode_reference(i_instruction);
        end else if (i_read_enable) begin
            exp_data_a <= debug_read(i_read_address);
        end
        if (i_enable && i_reg_write && i_write_reg != '0) begin
            model_regs[i_write_reg] <= i_write_data;
        end
    end

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Mismatch at time %0t: %s got %h, expected %h", $time, field, got, expected);
        fail_run();
    endtask

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", cycle_count);
            fail_run();
        end
    end

    a_data_a: assert property (@(posedge i_clock) exp_valid |-> o_data_a == exp_data_a)
        else report_mismatch("o_data_a", $sampled(o_data_a), $sampled(exp_data_a));
    a_data_b: assert property (@(posedge i_clock) exp_valid |-> o_data_b == exp_data_b)
        else report_mismatch("o_data_b", $sampled(o_data_b), $sampled(exp_data_b));
    a_imm: assert property (@(posedge i_clock) exp_valid |-> o_immediate == exp_dec.imm)
        else report_mismatch("o_immediate", $sampled(o_immediate), $sampled(exp_dec.imm));
    a_dest: assert property (@(posedge i_clock) exp_valid |-> o_dest_reg == exp_dec.dest)
        else report_mismatch("o_dest_reg", 32'($sampled(o_dest_reg)),
                             32'($sampled(exp_dec.dest)));
    a_reg_write: assert property (@(posedge i_clock)
        exp_valid |-> o_reg_write == exp_dec.ctrl.reg_write)
        else report_mismatch("o_reg_write", 32'($sampled(o_reg_write)),
                             32'($sampled(exp_dec.ctrl.reg_write)));
    a_mem_read: assert property (@(posedge i_clock)
        exp_valid |-> o_mem_read == exp_dec.ctrl.mem_read)
        else report_mismatch("o_mem_read", 32'($sampled(o_mem_read)),
                             32'($sampled(exp_dec.ctrl.mem_read)));
    a_mem_write: assert property (@(posedge i_clock)
        exp_valid |-> o_mem_write == exp_dec.ctrl.mem_write)
        else report_mismatch("o_mem_write", 32'($sampled(o_mem_write)),
                             32'($sampled(exp_dec.ctrl.mem_write)));
    a_mem_to_reg: assert property (@(posedge i_clock)
        exp_valid |-> o_mem_to_reg == exp_dec.ctrl.mem_to_reg)
        else report_mismatch("o_mem_to_reg", 32'($sampled(o_mem_to_reg)),
                             32'($sampled(exp_dec.ctrl.mem_to_reg)));
    a_alu_src: assert property (@(posedge i_clock)
        exp_valid |-> o_alu_src == exp_dec.ctrl.alu_src)
        else report_mismatch("o_alu_src", 32'($sampled(o_alu_src)),
                             32'($sampled(exp_dec.ctrl.alu_src)));
    a_branch: assert property (@(posedge i_clock)
        exp_valid |-> o_branch == exp_dec.ctrl.branch)
        else report_mismatch("o_branch", 32'($sampled(o_branch)),
                             32'($sampled(exp_dec.ctrl.branch)));
    a_alu_op: assert property (@(posedge i_clock)
        exp_valid |-> o_alu_op == exp_dec.ctrl.alu_op)
        else report_mismatch("o_alu_op", 32'($sampled(o_alu_op)),
                             32'($sampled(exp_dec.ctrl.alu_op)));
    a_illegal: assert property (@(posedge i_clock)
        exp_valid |-> o_illegal == exp_dec.illegal)
        else report_mismatch("o_illegal", 32'($sampled(o_illegal)),
                             32'($sampled(exp_dec.illegal)));

    task automatic next_cycle();
        @(posedge i_clock);
        #2;
    endtask

    task automatic decode_cycle(input logic [31:0] instr, input logic we,
                                input logic [4:0] wreg, input logic [31:0] wdata);
        i_enable      = 1'b1;
        i_read_enable = 1'b0;
        i_instruction = instr;
        i_reg_write   = we;
        i_write_reg   = wreg;
        i_write_data  = wdata;
        next_cycle();
    endtask

    task automatic halt_cycle(input logic [31:0] instr, input logic we, input logic [4:0] wreg,
                              input logic [31:0] wdata, input logic re, input logic [4:0] raddr);
        i_enable       = 1'b0;
        i_instruction  = instr;
        i_reg_write    = we;
        i_write_reg    = wreg;
        i_write_data   = wdata;
        i_read_enable  = re;
        i_read_address = raddr;
        next_cycle();
    endtask

    // Supported or arbitrary instruction reading rs and rt
    function automatic logic [31:0] random_instruction(input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] r;
        r = next_random();
        if (r[3:0] < 4'd5) return make_r(R_FUNCTS[r[3:0]], rs, rt, r[8:4]);
        if (r[3:0] < 4'd12) return make_i(I_OPS[r[3:0] - 4'd5], rs, rt, r[31:16]);
        if (r[3:0] == 4'd12) return make_r(r[21:16], rs, rt, r[8:4]); // Funct mostly unknown
        return {r[31:26], rs, rt, r[15:0]};
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] instr;
        logic [31:0] wdata;
        logic [4:0]  rs;
        logic [4:0]  rt;
        // Live load and forwarded write while reset is held
        i_reset        = 1'b1;
        i_enable       = 1'b1;
        i_instruction  = make_i(mips_isa_pkg::OP_LW, 5'd3, 5'd3, 16'h8001);
        i_reg_write    = 1'b1;
        i_write_reg    = 5'd3;
        i_write_data   = 32'hA5A5_5A5A;
        i_read_enable  = 1'b0;
        i_read_address = '0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        #2;
        i_reset = 1'b0;

        // Fill the bank, reading each register as it is written
        for (int k = 1; k < `BANK_DEPTH; k++) begin
            decode_cycle(make_r(mips_isa_pkg::FN_ADD, 5'(k), 5'(k), 5'(k)), 1'b1, 5'(k),
                         next_random());
        end

        // Register 0 ignores writes and is never forwarded
        decode_cycle(make_r(mips_isa_pkg::FN_OR, 5'd0, 5'd0, 5'd2), 1'b1, 5'd0, 32'hFFFF_FFFF);
        decode_cycle(make_r(mips_isa_pkg::FN_OR, 5'd0, 5'd0, 5'd2), 1'b0, '0, '0);
        decode_cycle(make_r(mips_isa_pkg::FN_ADD, 5'd5, 5'd6, 5'd1), 1'b1, 5'd5, 32'hA5A5_0001);
        decode_cycle(make_r(mips_isa_pkg::FN_SUB, 5'd6, 5'd9, 5'd1), 1'b1, 5'd9, 32'h5A5A_0002);
        decode_cycle(make_r(mips_isa_pkg::FN_OR, 5'd5, 5'd9, 5'd0), 1'b0, '0, '0);

        // Every supported instruction with both immediate signs
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 7; k++) begin
                decode_cycle(make_i(I_OPS[k], 5'd3, 5'd7, TEST_IMMS[m]), 1'b0, '0, '0);
            end
        end
        for (int k = 0; k < 5; k++) begin
            decode_cycle(make_r(R_FUNCTS[k], 5'd10, 5'd11, 5'd12), 1'b0, '0, '0);
        end
        decode_cycle(make_i(6'h3F, 5'd1, 5'd2, 16'h1234), 1'b0, '0, '0); // Unknown opcode
        decode_cycle(make_r(6'h3F, 5'd1, 5'd2, 5'd3), 1'b0, '0, '0);     // Unknown funct
        decode_cycle(make_i(6'h02, 5'd1, 5'd2, 16'hFFFF), 1'b0, '0, '0); // Jump, unsupported

        // Random traffic, often reading the register being written
        for (int i = 0; i < RANDOM_OPS; i++) begin
            r  = next_random();
            rs = r[9:5];
            rt = r[14:10];
            if (r[15]) rs = r[4:0];
            else if (r[16]) rt = r[4:0];
            instr = random_instruction(rs, rt);
            wdata = next_random();
            decode_cycle(instr, r[17], r[4:0], wdata);
        end

        // Halted, writes dropped and outputs frozen
        halt_cycle(make_r(mips_isa_pkg::FN_SUB, 5'd4, 5'd8, 5'd9), 1'b1, 5'd4, 32'hDEAD_BEEF,
                   1'b0, '0);
        halt_cycle(make_i(mips_isa_pkg::OP_LUI, 5'd1, 5'd2, 16'hCAFE), 1'b0, '0, '0, 1'b0, '0);
        halt_cycle(make_i(6'h3F, 5'd1, 5'd2, 16'h0000), 1'b0, '0, '0, 1'b1, 5'd0);
        halt_cycle(make_i(6'h3F, 5'd1, 5'd2, 16'h0000), 1'b1, 5'd4, 32'h1111_2222, 1'b1, 5'd4);
        for (int k = 0; k < 6; k++) begin
            r = next_random();
            halt_cycle(r, 1'b0, '0, '0, 1'b1, r[4:0]);
        end
        halt_cycle(make_r(mips_isa_pkg::FN_AND, 5'd7, 5'd8, 5'd9), 1'b0, '0, '0, 1'b0, 5'd31);

        // Resume and confirm register 4 kept its value
        decode_cycle(make_r(mips_isa_pkg::FN_ADD, 5'd4, 5'd0, 5'd1), 1'b0, '0, '0);
        decode_cycle(make_i(mips_isa_pkg::OP_ORI, 5'd0, 5'd4, 16'h00FF), 1'b0, '0, '0);
        next_cycle();
        next_cycle();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
mips_isa_pkg.sv
decode_ctrl_pkg.sv
reg_read_if.sv
register_bank.sv
instruction_decoder.sv
decode_stage.sv
tb_decode_stage.sv

//--- Makefile
# Verilator build for the decode stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_decode_stage
DUT_TOP    ?= decode_stage
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a nonzero exit status, which fails make
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
